// ==== coreMemSys.f ====
source/coreMemPkg.sv
source/storeQueue.sv
source/loadUnit.sv
source/busArbiter.sv
source/controlRegs.sv
source/coreMemSys.sv
tests/wbMemModel.sv
tests/coreMemSysTb.sv

// ==== source/busArbiter.sv ====
`timescale 1ns/1ns

module busArbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  coreMemPkg::wbMaster_t loadReq,
    input  coreMemPkg::wbMaster_t storeReq,
    input  coreMemPkg::wbSlave_t  ctrlResp,
    input  coreMemPkg::wbSlave_t  extResp,
    output coreMemPkg::wbSlave_t  loadResp,
    output coreMemPkg::wbSlave_t  storeResp,
    output coreMemPkg::wbMaster_t ctrlReq,
    output coreMemPkg::wbMaster_t extReq
);
    import coreMemPkg::*;

    typedef enum logic [1:0] {
        none,
        load,
        store
    } grant_t;

    grant_t    grant;
    wbMaster_t granted;
    logic      toCtrl;
    logic      slaveAck;
    data_t     slaveDat;

    always_comb begin
        case (grant)
            load:    granted = loadReq;
            store:   granted = storeReq;
            default: granted = '0;
        endcase
    end

    // Address decode on the granted cycle
    assign toCtrl = granted.adr[CTRL_REGION_BIT];

    always_comb begin
        ctrlReq = granted;
        extReq  = granted;
        if (toCtrl) begin
            extReq.cyc = 1'b0;
            extReq.stb = 1'b0;
        end else begin
            ctrlReq.cyc = 1'b0;
            ctrlReq.stb = 1'b0;
        end
    end

    assign slaveAck = granted.cyc && (toCtrl ? ctrlResp.ack : extResp.ack);
    assign slaveDat = toCtrl ? ctrlResp.dat : extResp.dat;

    always_comb begin
        loadResp.ack  = slaveAck && (grant == load);
        loadResp.dat  = slaveDat;
        storeResp.ack = slaveAck && (grant == store);
        storeResp.dat = slaveDat;
    end

    // Load wins a tie; grant sticks until ack
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= none;
        end else begin
            case (grant)
                none: begin
                    if (loadReq.cyc) begin
                        grant <= load;
                    end else if (storeReq.cyc) begin
                        grant <= store;
                    end
                end
                default: begin
                    if (slaveAck) begin
                        grant <= none;
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/controlRegs.sv ====
`timescale 1ns/1ns

module controlRegs (
    input  logic                              clk,
    input  logic                              rst,
    input  coreMemPkg::wbMaster_t             bus,
    input  logic [coreMemPkg::GPIO_WIDTH-1:0] gpioIn,
    output coreMemPkg::wbSlave_t              resp,
    output logic [coreMemPkg::GPIO_WIDTH-1:0] gpioOut,
    output logic [coreMemPkg::GPIO_WIDTH-1:0] gpioOe
);
    import coreMemPkg::*;

    typedef logic [GPIO_WIDTH-1:0]      gpio_t;
    typedef logic [CTRL_REGION_BIT-1:0] regOffset_t;

    gpio_t      gpioInReg;
    regOffset_t offset;
    logic       access;
    logic       ack;
    data_t      rdData;

    assign offset = bus.adr[CTRL_REGION_BIT-1:0];
    // One access per strobe, the ack cycle is not a second one
    assign access = bus.cyc && bus.stb && !ack;

    always_ff @(posedge clk) begin
        gpioInReg <= gpioIn;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            gpioOut <= '0;
            gpioOe  <= '0;
        end else begin
            ack <= access;
            if (access && bus.we) begin
                for (int b = 0; b < GPIO_WIDTH / 8; b++) begin
                    if (bus.sel[b] && offset == regOffset_t'(GPIO_OUT_OFFSET)) begin
                        gpioOut[b*8 +: 8] <= bus.dat[b*8 +: 8];
                    end
                    if (bus.sel[b] && offset == regOffset_t'(GPIO_OE_OFFSET)) begin
                        gpioOe[b*8 +: 8] <= bus.dat[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (offset)
                regOffset_t'(GPIO_OUT_OFFSET): rdData <= data_t'(gpioOut);
                regOffset_t'(GPIO_OE_OFFSET):  rdData <= data_t'(gpioOe);
                regOffset_t'(GPIO_IN_OFFSET):  rdData <= data_t'(gpioInReg);
                default:                       rdData <= '0;
            endcase
        end
    end

    assign resp = '{ack: ack, dat: rdData};

endmodule

// ==== source/coreMemPkg.sv ====
package coreMemPkg;

    typedef logic [5:0]  sqN_t;
    typedef logic [6:0]  tag_t;
    typedef logic [29:0] wordAddr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  mask_t;

    // Address map, word addresses
    localparam int CTRL_REGION_BIT = 29;
    localparam int GPIO_OUT_OFFSET = 0;
    localparam int GPIO_OE_OFFSET  = 1;
    localparam int GPIO_IN_OFFSET  = 2;
    localparam int GPIO_WIDTH      = 16;

    typedef struct packed {
        logic      valid;
        logic      isLoad;
        sqN_t      sqN;
        tag_t      tag;
        wordAddr_t addr;
        data_t     data;
        mask_t     mask;
    } memReq_t;

    typedef struct packed {
        logic taken;
        sqN_t sqN;
    } flush_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } loadResult_t;

    // Wishbone master outputs
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        mask_t     sel;
        wordAddr_t adr;
        data_t     dat;
    } wbMaster_t;

    // Wishbone slave outputs
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wbSlave_t;

    // Sequence numbers wrap, so age is the sign of the difference
    function automatic logic isOlder(sqN_t a, sqN_t b);
        sqN_t diff;
        diff = a - b;
        return diff[$bits(sqN_t)-1];
    endfunction

endpackage

// ==== source/coreMemSys.sv ====
`timescale 1ns/1ns

module coreMemSys #(
    parameter int STORE_QUEUE_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  coreMemPkg::memReq_t               memReq,
    input  coreMemPkg::sqN_t                  commitSqN,
    input  coreMemPkg::flush_t                flush,
    input  coreMemPkg::wbSlave_t              wbIn,
    input  logic [coreMemPkg::GPIO_WIDTH-1:0] gpioIn,
    output logic                              memReqReady,
    output coreMemPkg::loadResult_t           loadResult,
    output coreMemPkg::wbMaster_t             wbOut,
    output logic [coreMemPkg::GPIO_WIDTH-1:0] gpioOut,
    output logic [coreMemPkg::GPIO_WIDTH-1:0] gpioOe
);
    import coreMemPkg::*;

    logic      sqFull;
    logic      sqPending;
    sqN_t      sqOldest;
    logic      luBusy;
    logic      take;
    memReq_t   storeIn;
    memReq_t   loadIn;
    wbMaster_t storeBus;
    wbMaster_t loadBus;
    wbMaster_t ctrlReq;
    wbSlave_t  storeResp;
    wbSlave_t  loadResp;
    wbSlave_t  ctrlResp;

    assign memReqReady = !sqFull && !luBusy;
    assign take        = memReq.valid && memReqReady;

    // Split by kind
    always_comb begin
        storeIn       = memReq;
        storeIn.valid = take && !memReq.isLoad;
        loadIn        = memReq;
        loadIn.valid  = take && memReq.isLoad;
    end

    storeQueue #(
        .STORE_QUEUE_DEPTH(STORE_QUEUE_DEPTH)
    ) sq (
        .clk(clk),
        .rst(rst),
        .storeIn(storeIn),
        .commitSqN(commitSqN),
        .flush(flush),
        .bus(storeResp),
        .full(sqFull),
        .pendingValid(sqPending),
        .oldestSqN(sqOldest),
        .busReq(storeBus)
    );

    loadUnit lu (
        .clk(clk),
        .rst(rst),
        .loadIn(loadIn),
        .flush(flush),
        .pendingValid(sqPending),
        .oldestSqN(sqOldest),
        .bus(loadResp),
        .busy(luBusy),
        .busReq(loadBus),
        .loadResult(loadResult)
    );

    busArbiter arb (
        .clk(clk),
        .rst(rst),
        .loadReq(loadBus),
        .storeReq(storeBus),
        .ctrlResp(ctrlResp),
        .extResp(wbIn),
        .loadResp(loadResp),
        .storeResp(storeResp),
        .ctrlReq(ctrlReq),
        .extReq(wbOut)
    );

    controlRegs cr (
        .clk(clk),
        .rst(rst),
        .bus(ctrlReq),
        .gpioIn(gpioIn),
        .resp(ctrlResp),
        .gpioOut(gpioOut),
        .gpioOe(gpioOe)
    );

endmodule

// ==== source/loadUnit.sv ====
`timescale 1ns/1ns

module loadUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  coreMemPkg::memReq_t     loadIn,
    input  coreMemPkg::flush_t      flush,
    input  logic                    pendingValid,
    input  coreMemPkg::sqN_t        oldestSqN,
    input  coreMemPkg::wbSlave_t    bus,
    output logic                    busy,
    output coreMemPkg::wbMaster_t   busReq,
    output coreMemPkg::loadResult_t loadResult
);
    import coreMemPkg::*;

    typedef enum logic [1:0] {
        idle,
        waitStores,
        busRead,
        drop
    } loadState_t;

    loadState_t state;
    sqN_t       sqN;
    tag_t       tag;
    wordAddr_t  addr;
    logic       inFlushed;
    logic       heldFlushed;
    logic       storesClear;
    logic       resultValid;
    tag_t       resultTag;
    data_t      resultData;

    assign inFlushed   = flush.taken && isOlder(flush.sqN, loadIn.sqN);
    assign heldFlushed = flush.taken && isOlder(flush.sqN, sqN);
    // Queue is ordered, so checking the oldest store is enough
    assign storesClear = !(pendingValid && isOlder(oldestSqN, sqN));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (loadIn.valid && !inFlushed) begin
                        state <= waitStores;
                    end
                end
                waitStores: begin
                    if (heldFlushed) begin
                        state <= idle;
                    end else if (storesClear) begin
                        state <= busRead;
                    end
                end
                busRead: begin
                    if (bus.ack) begin
                        state <= idle;
                    end else if (heldFlushed) begin
                        state <= drop;
                    end
                end
                default: begin
                    if (bus.ack) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && loadIn.valid) begin
            sqN  <= loadIn.sqN;
            tag  <= loadIn.tag;
            addr <= loadIn.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= (state == busRead) && bus.ack && !heldFlushed;
        end
    end

    always_ff @(posedge clk) begin
        if (state == busRead && bus.ack) begin
            resultTag  <= tag;
            resultData <= bus.dat;
        end
    end

    assign busy = (state != idle);

    always_comb begin
        busReq.cyc = (state == busRead) || (state == drop);
        busReq.stb = busReq.cyc;
        busReq.we  = 1'b0;
        busReq.sel = '1;
        busReq.adr = addr;
        busReq.dat = '0;
    end

    assign loadResult = '{valid: resultValid, tag: resultTag, data: resultData};

endmodule

// ==== source/storeQueue.sv ====
`timescale 1ns/1ns

module storeQueue #(
    parameter int STORE_QUEUE_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  coreMemPkg::memReq_t   storeIn,
    input  coreMemPkg::sqN_t      commitSqN,
    input  coreMemPkg::flush_t    flush,
    input  coreMemPkg::wbSlave_t  bus,
    output logic                  full,
    output logic                  pendingValid,
    output coreMemPkg::sqN_t      oldestSqN,
    output coreMemPkg::wbMaster_t busReq
);
    import coreMemPkg::*;

    localparam int PTR_W = (STORE_QUEUE_DEPTH > 1) ? $clog2(STORE_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(STORE_QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    memReq_t entries [STORE_QUEUE_DEPTH];
    memReq_t headEntry;
    ptr_t    head;
    ptr_t    tailIdx;
    count_t  count;
    count_t  keepCount;
    count_t  liveCount;
    logic    writing;
    logic    storeFlushed;
    logic    pushOk;
    logic    popNow;
    logic    startWrite;

    function automatic ptr_t nextPtr(ptr_t p);
        if (int'(p) == STORE_QUEUE_DEPTH - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign headEntry = entries[head];

    // Entries are in sqN order, so the survivors of a flush form a prefix
    always_comb begin
        int slot;
        keepCount = '0;
        for (int k = 0; k < STORE_QUEUE_DEPTH; k++) begin
            slot = (int'(head) + k) % STORE_QUEUE_DEPTH;
            if (count_t'(k) < count && !isOlder(flush.sqN, entries[slot].sqN)) begin
                keepCount = count_t'(k + 1);
            end
        end
        // Never pull the entry that is on the bus
        if (writing && keepCount == '0) begin
            keepCount = count_t'(1);
        end
    end

    assign liveCount    = flush.taken ? keepCount : count;
    assign tailIdx      = ptr_t'((int'(head) + int'(liveCount)) % STORE_QUEUE_DEPTH);
    assign storeFlushed = flush.taken && isOlder(flush.sqN, storeIn.sqN);
    assign pushOk       = storeIn.valid && !storeFlushed;
    assign popNow       = writing && bus.ack;

    // Head goes out once commit has passed it
    assign startWrite = !writing && liveCount != '0 && isOlder(headEntry.sqN, commitSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            count   <= '0;
            writing <= 1'b0;
        end else begin
            count <= liveCount + count_t'(pushOk) - count_t'(popNow);
            if (popNow) begin
                head    <= nextPtr(head);
                writing <= 1'b0;
            end else if (startWrite) begin
                writing <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pushOk) begin
            entries[tailIdx] <= storeIn;
        end
    end

    assign full         = (count == count_t'(STORE_QUEUE_DEPTH));
    assign pendingValid = (count != '0);
    assign oldestSqN    = headEntry.sqN;

    always_comb begin
        busReq.cyc = writing;
        busReq.stb = writing;
        busReq.we  = 1'b1;
        busReq.sel = headEntry.mask;
        busReq.adr = headEntry.addr;
        busReq.dat = headEntry.data;
    end

endmodule

// ==== tests/coreMemSysTb.sv ====
`timescale 1ns/1ns

module coreMemSysTb;
    import coreMemPkg::*;

    localparam int STORE_QUEUE_DEPTH = 8;
    // 6 tests, up to 40 ops of up to 8 cycles, plus headroom
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int WAIT_LIMIT     = 200;
    localparam wordAddr_t CTRL_BASE = wordAddr_t'(1) << CTRL_REGION_BIT;

    logic                  clk;
    logic                  rst;
    memReq_t               memReq;
    sqN_t                  commitSqN;
    flush_t                flush;
    wbSlave_t              wbIn;
    logic [GPIO_WIDTH-1:0] gpioIn;
    logic                  memReqReady;
    loadResult_t           loadResult;
    wbMaster_t             wbOut;
    logic [GPIO_WIDTH-1:0] gpioOut;
    logic [GPIO_WIDTH-1:0] gpioOe;

    int        errors;
    int        errorsBefore;
    int        testNum;
    int        testsPassed;
    int        testsFailed;
    int        cycles;
    int        resultCount;
    logic      holding;
    logic      lastValid;
    wbMaster_t heldBus;
    sqN_t      nextSq;

    coreMemSys #(
        .STORE_QUEUE_DEPTH(STORE_QUEUE_DEPTH)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .memReq(memReq),
        .commitSqN(commitSqN),
        .flush(flush),
        .wbIn(wbIn),
        .gpioIn(gpioIn),
        .memReqReady(memReqReady),
        .loadResult(loadResult),
        .wbOut(wbOut),
        .gpioOut(gpioOut),
        .gpioOe(gpioOe)
    );

    wbMemModel extMem (
        .clk(clk),
        .rst(rst),
        .bus(wbOut),
        .resp(wbIn)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic reportFailure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        errors++;
    endtask

    function automatic data_t mergeBytes(data_t old, data_t data, mask_t mask);
        data_t merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Holds the request until ready, then it is taken at the next edge
    task automatic sendReq(input logic isLoad, input tag_t tag, input wordAddr_t addr,
                           input data_t data, input mask_t mask);
        int waited;
        waited = 0;
        memReq = '{valid: 1'b1, isLoad: isLoad, sqN: nextSq, tag: tag, addr: addr,
                   data: data, mask: mask};
        while (!memReqReady && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        assert (memReqReady) else reportFailure("memReqReady stayed low, request not taken");
        step();
        memReq.valid = 1'b0;
        nextSq++;
    endtask

    task automatic waitWrites(input int target);
        int waited;
        waited = 0;
        while (extMem.writeCount < target && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        assert (extMem.writeCount >= target) else reportFailure("memory writes never arrived");
    endtask

    task automatic waitLoad(output loadResult_t res);
        int waited;
        waited = 0;
        while (!loadResult.valid && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        assert (loadResult.valid) else reportFailure("no load result arrived");
        res = loadResult;
    endtask

    task automatic endTest(input string name);
        testNum++;
        if (errors == errorsBefore) begin
            testsPassed++;
            $display("Test %0d %s: passed", testNum, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed", testNum, name);
        end
        errorsBefore = errors;
    endtask

    // Wishbone classic, request frozen until ack
    always @(negedge clk) begin
        if (!rst && holding) begin
            assert (wbOut === heldBus) else reportFailure("wbOut changed before ack");
        end
        holding = !rst && wbOut.cyc && !wbIn.ack;
        heldBus = wbOut;
    end

    always @(negedge clk) begin
        if (!rst && loadResult.valid) begin
            assert (!lastValid) else reportFailure("loadResult.valid lasted over one cycle");
            resultCount++;
        end
        lastValid = !rst && loadResult.valid;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        loadResult_t res;
        data_t       old;
        data_t       old2;
        data_t       d;
        data_t       d2;
        data_t       fillData [STORE_QUEUE_DEPTH];
        int          base;
        int          count;
        void'($urandom(32'hf0));
        rst       = 1'b1;
        memReq    = '0;
        commitSqN = '0;
        flush     = '0;
        gpioIn    = '0;
        nextSq    = sqN_t'(1);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        checkValue("memReqReady", memReqReady, 1);
        checkValue("wbOut.cyc", wbOut.cyc, 0);
        checkValue("loadResult.valid", loadResult.valid, 0);
        checkValue("gpioOut", gpioOut, 0);
        checkValue("gpioOe", gpioOe, 0);
        endTest("reset");

        old  = extMem.words[10];
        d    = $urandom();
        base = extMem.writeCount;
        sendReq(1'b0, '0, wordAddr_t'(10), d, 4'b0101);
        repeat (20) step();
        checkValue("memory write count", extMem.writeCount, base);
        commitSqN = nextSq;
        waitWrites(base + 1);
        checkValue("mem word 10", extMem.words[10], mergeBytes(old, d, 4'b0101));
        endTest("commit gates stores");

        d = $urandom();
        sendReq(1'b0, '0, wordAddr_t'(20), d, 4'hf);
        sendReq(1'b1, 7'h15, wordAddr_t'(20), '0, '0);
        count = resultCount;
        repeat (10) step();
        checkValue("load results before commit", resultCount, count);
        commitSqN = nextSq;
        waitLoad(res);
        checkValue("loadResult.tag", res.tag, 7'h15);
        checkValue("loadResult.data", res.data, d);
        sendReq(1'b1, 7'h16, wordAddr_t'(30), '0, '0);
        waitLoad(res);
        checkValue("loadResult.tag", res.tag, 7'h16);
        checkValue("loadResult.data", res.data, extMem.words[30]);
        endTest("load after older store");

        // Gap in sqN so the flush point sits strictly between the two stores
        base = extMem.writeCount;
        old  = extMem.words[40];
        old2 = extMem.words[41];
        d    = $urandom();
        d2   = $urandom();
        sendReq(1'b0, '0, wordAddr_t'(40), d, 4'b1100);
        nextSq++;
        sendReq(1'b0, '0, wordAddr_t'(41), d2, 4'hf);
        flush = '{taken: 1'b1, sqN: sqN_t'(nextSq - 2)};
        step();
        flush     = '0;
        commitSqN = nextSq;
        waitWrites(base + 1);
        repeat (20) step();
        checkValue("memory write count", extMem.writeCount, base + 1);
        checkValue("mem word 40", extMem.words[40], mergeBytes(old, d, 4'b1100));
        checkValue("mem word 41", extMem.words[41], old2);
        count = resultCount;
        sendReq(1'b1, 7'h21, wordAddr_t'(60), '0, '0);
        step();
        flush = '{taken: 1'b1, sqN: sqN_t'(nextSq - 2)};
        step();
        flush = '0;
        repeat (20) step();
        checkValue("load results after flush", resultCount, count);
        checkValue("memReqReady", memReqReady, 1);
        endTest("flush");

        base = extMem.writeCount;
        for (int k = 0; k < STORE_QUEUE_DEPTH; k++) begin
            fillData[k] = $urandom();
            sendReq(1'b0, '0, wordAddr_t'(50 + k), fillData[k], 4'hf);
        end
        checkValue("memReqReady", memReqReady, 0);
        commitSqN = nextSq;
        waitWrites(base + STORE_QUEUE_DEPTH);
        for (int k = 0; k < STORE_QUEUE_DEPTH; k++) begin
            checkValue($sformatf("write log %0d", k), extMem.writeLog[(base + k) % 256], 50 + k);
            checkValue($sformatf("mem word %0d", 50 + k), extMem.words[50 + k], fillData[k]);
        end
        checkValue("memReqReady", memReqReady, 1);
        endTest("back-pressure");

        base   = extMem.writeCount;
        count  = extMem.accessCount;
        d      = $urandom();
        d2     = $urandom();
        gpioIn = GPIO_WIDTH'($urandom());
        sendReq(1'b0, '0, CTRL_BASE | wordAddr_t'(GPIO_OUT_OFFSET), d, 4'b0011);
        sendReq(1'b0, '0, CTRL_BASE | wordAddr_t'(GPIO_OE_OFFSET), d2, 4'b0001);
        sendReq(1'b1, 7'h2a, CTRL_BASE | wordAddr_t'(GPIO_IN_OFFSET), '0, '0);
        commitSqN = nextSq;
        // Load waits for both stores, so its result follows their acks
        waitLoad(res);
        checkValue("gpioOut", gpioOut, d[15:0]);
        checkValue("gpioOe", gpioOe, {8'h00, d2[7:0]});
        checkValue("loadResult.tag", res.tag, 7'h2a);
        checkValue("loadResult.data", res.data, {16'h0000, gpioIn});
        checkValue("memory access count", extMem.accessCount, count);
        checkValue("memory write count", extMem.writeCount, base);
        endTest("GPIO");

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 testNum, testsPassed, testsFailed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tests/wbMemModel.sv ====
`timescale 1ns/1ns

module wbMemModel (
    input  logic                  clk,
    input  logic                  rst,
    input  coreMemPkg::wbMaster_t bus,
    output coreMemPkg::wbSlave_t  resp
);
    import coreMemPkg::*;

    data_t     words [256];
    wordAddr_t writeLog [256];
    int        writeCount;
    int        accessCount;
    logic      busy;
    int        waitLeft;

    // Fill uses the whole index so aliased reads stand out
    initial begin
        for (int i = 0; i < 256; i++) begin
            words[i] = (i * 32'h01000193) ^ 32'h5a5a5a5a;
        end
        resp        = '0;
        busy        = 1'b0;
        waitLeft    = 0;
        writeCount  = 0;
        accessCount = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            resp.ack <= 1'b0;
            busy     <= 1'b0;
        end else begin
            resp.ack <= 1'b0;
            if (bus.cyc && bus.stb && !resp.ack) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    waitLeft <= $urandom_range(3, 0);
                end else if (waitLeft > 0) begin
                    waitLeft <= waitLeft - 1;
                end else begin
                    busy        <= 1'b0;
                    resp.ack    <= 1'b1;
                    resp.dat    <= words[bus.adr[7:0]];
                    accessCount <= accessCount + 1;
                    if (bus.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (bus.sel[b]) begin
                                words[bus.adr[7:0]][b*8 +: 8] <= bus.dat[b*8 +: 8];
                            end
                        end
                        writeLog[writeCount % 256] <= bus.adr;
                        writeCount                 <= writeCount + 1;
                    end
                end
            end
        end
    end

endmodule
